//--- files.f
+incdir+src
src/wguard_pkg.sv
src/hs_sampler.sv
src/txn_tracker.sv
src/timeout_handler.sv
src/write_guard.sv
verification/write_guard_props.sv
verification/tb_write_guard.sv

//--- Makefile
# Verilator build and run of the write guard testbench

VERILATOR ?= verilator
TOP       ?= tb_write_guard
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) src/wguard_cfg.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_write_guard.sv
// Testbench for the write guard
// A bus model drives AW, W and B handshakes on the falling edge, a reference
// function predicts the timeout cause from the measured phase durations and
// a compare process checks irq_o, reset_req_o and cause_o after each scenario

`timescale 1ns/1ps
`include "wguard_cfg.svh"

module tb_write_guard;

  import wguard_pkg::*;

  localparam int PS         = `WG_PRESCALE;
  localparam int ID_W       = `WG_ID_W;
  localparam int CNT_W      = `WG_CNT_W;
  localparam int MAX_CYCLES = 20000;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic             aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i;
  logic             b_valid_i, b_ready_i, reset_clear_i;
  logic [ID_W-1:0]  aw_id_i, b_id_i;
  logic [CNT_W-1:0] budget_aw_i, budget_w_i, budget_b_i, budget_brdy_i;
  logic             irq_o, reset_req_o, full_o;
  tmo_cause_e       cause_o;

  int         cycle_cnt = 0;
  int         error_cnt = 0;
  int         check_cnt = 0;
  int         bud [4];
  // Longest duration seen per phase in the current scenario
  int         dur [4];
  tmo_cause_e exp_cause;
  logic       check_req = 1'b0;

  write_guard u_dut (
    .clk_i, .rst_n_i, .aw_valid_i, .aw_ready_i, .aw_id_i, .w_valid_i, .w_ready_i,
    .w_last_i, .b_valid_i, .b_ready_i, .b_id_i, .budget_aw_i, .budget_w_i,
    .budget_b_i, .budget_brdy_i, .reset_clear_i, .irq_o, .reset_req_o, .cause_o,
    .full_o
  );

  always #4 clk_i = ~clk_i;

  // Cycle counter and run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run aborted, no end of test after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Phases either stay inside the safe margin of budget*PS-4 clocks
  // or run well past the overrun bound, so the safe margin decides
  function automatic tmo_cause_e expected_cause(input int d [4], input int b [4]);
    for (int p = 0; p < 4; p++) begin
      if (d[p] > b[p] * PS - 4) begin
        case (p)
          0:       return CAUSE_AW;
          1:       return CAUSE_W;
          2:       return CAUSE_B;
          default: return CAUSE_BRDY;
        endcase
      end
    end
    return CAUSE_NONE;
  endfunction

  task automatic check(input string what, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      error_cnt++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  always @(posedge clk_i) begin
    if (check_req) begin
      check("irq_o", int'(irq_o), int'(exp_cause != CAUSE_NONE));
      check("reset_req_o", int'(reset_req_o), int'(exp_cause != CAUSE_NONE));
      check("cause_o", int'(cause_o), int'(exp_cause));
      check_req <= 1'b0;
    end
  end

  task automatic step(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic note_dur(input int p, input int d);
    if (d > dur[p]) begin
      dur[p] = d;
    end
  endtask

  task automatic set_budgets(input int a, input int w, input int b, input int r);
    bud[0] = a;
    bud[1] = w;
    bud[2] = b;
    bud[3] = r;
    budget_aw_i   = CNT_W'(a);
    budget_w_i    = CNT_W'(w);
    budget_b_i    = CNT_W'(b);
    budget_brdy_i = CNT_W'(r);
  endtask

  task automatic aw_txn(input int id, input int dly, output int t_done);
    int t0;
    t0 = cycle_cnt;
    aw_valid_i = 1'b1;
    aw_id_i    = ID_W'(id);
    step(dly);
    aw_ready_i = 1'b1;
    step(1);
    aw_valid_i = 1'b0;
    aw_ready_i = 1'b0;
    t_done = cycle_cnt;
    note_dur(0, t_done - t0);
    step(2);
  endtask

  // Single-beat write where every beat is the last one
  task automatic w_txn(input int t_aw, input int dly, output int t_done);
    w_valid_i = 1'b1;
    w_last_i  = 1'b1;
    step(dly);
    w_ready_i = 1'b1;
    step(1);
    w_valid_i = 1'b0;
    w_ready_i = 1'b0;
    w_last_i  = 1'b0;
    t_done = cycle_cnt;
    note_dur(1, t_done - t_aw);
    step(1);
  endtask

  task automatic b_txn(input int id, input int t_wl, input int wait_c, input int dly);
    int t_bv;
    step(wait_c);
    b_valid_i = 1'b1;
    b_id_i    = ID_W'(id);
    t_bv = cycle_cnt;
    note_dur(2, t_bv - t_wl);
    step(dly);
    b_ready_i = 1'b1;
    step(1);
    b_valid_i = 1'b0;
    b_ready_i = 1'b0;
    note_dur(3, cycle_cnt - t_bv);
    step(1);
  endtask

  // Let the pipeline settle, compare, then clear a raised interrupt
  task automatic finish_scen();
    step(6);
    exp_cause = expected_cause(dur, bud);
    check_req = 1'b1;
    while (check_req) begin
      step(1);
    end
    if (exp_cause != CAUSE_NONE) begin
      reset_clear_i = 1'b1;
      step(1);
      reset_clear_i = 1'b0;
      step(2);
      check("irq_o after clear", int'(irq_o), 0);
      check("cause_o after clear", int'(cause_o), int'(CAUSE_NONE));
    end
    for (int p = 0; p < 4; p++) begin
      dur[p] = 0;
    end
  endtask

  // Up to WG_TXNS writes in flight with B answered in shuffled order
  task automatic random_round();
    int n, base, k, tmp, t_aw;
    int ids [`WG_TXNS];
    int t_wl [`WG_TXNS];
    int ord [`WG_TXNS];
    set_budgets(24, 24, 24, 24);
    n = 1 + int'($urandom % `WG_TXNS);
    base = int'($urandom % (1 << ID_W));
    for (int i = 0; i < n; i++) begin
      ids[i] = (base + i) % (1 << ID_W);
      ord[i] = i;
      aw_txn(ids[i], int'($urandom % 4), t_aw);
      w_txn(t_aw, int'($urandom % 4), t_wl[i]);
    end
    for (int i = n - 1; i > 0; i--) begin
      k = int'($urandom % (i + 1));
      tmp = ord[i];
      ord[i] = ord[k];
      ord[k] = tmp;
    end
    for (int i = 0; i < n; i++) begin
      b_txn(ids[ord[i]], t_wl[ord[i]], int'($urandom % 3), int'($urandom % 4));
    end
    finish_scen();
  endtask

  // One phase held well past its short budget
  task automatic stall_round(input int p);
    int id, t_aw, t_wl;
    set_budgets(24, 24, 24, 24);
    bud[p] = 3;
    set_budgets(bud[0], bud[1], bud[2], bud[3]);
    id = int'($urandom % (1 << ID_W));
    aw_txn(id, (p == 0) ? 27 : int'($urandom % 3), t_aw);
    w_txn(t_aw, (p == 1) ? 27 : int'($urandom % 3), t_wl);
    b_txn(id, t_wl, (p == 2) ? 28 : 0, (p == 3) ? 27 : int'($urandom % 3));
    finish_scen();
  endtask

  // IDs 3 and 1 answer on time and ID 2 answers late.
  // ID 3 opens after a pause, so B matched to the oldest entry
  // regardless of ID would leave no entry overdue
  task automatic late_id_round();
    int t_aw;
    int t_wl [3];
    set_budgets(24, 24, 16, 24);
    for (int i = 0; i < 3; i++) begin
      if (i == 2) begin
        step(30);
      end
      aw_txn(i + 1, 0, t_aw);
      w_txn(t_aw, 0, t_wl[i]);
    end
    b_txn(3, t_wl[2], 0, 0);
    b_txn(1, t_wl[0], 0, 0);
    b_txn(2, t_wl[1], 44, 0);
    finish_scen();
  endtask

  // One write more than the table holds so the last goes untracked
  task automatic full_round();
    int t_aw, t_wl;
    set_budgets(200, 200, 200, 200);
    for (int i = 1; i <= `WG_TXNS + 1; i++) begin
      aw_txn(i, 0, t_aw);
      w_txn(t_aw, 0, t_wl);
    end
    step(3);
    check("full_o with table full", int'(full_o), 1);
    b_txn(1, t_wl, 0, 0);
    step(2);
    check("full_o after one B", int'(full_o), 0);
    for (int i = 2; i <= `WG_TXNS + 1; i++) begin
      b_txn(i, t_wl, 0, 0);
    end
    for (int p = 0; p < 4; p++) begin
      dur[p] = 0;
    end
    finish_scen();
  endtask

  initial begin
    void'($urandom(20));
    rst_n_i       = 1'b0;
    aw_valid_i    = 1'b0;
    aw_ready_i    = 1'b0;
    aw_id_i       = '0;
    w_valid_i     = 1'b0;
    w_ready_i     = 1'b0;
    w_last_i      = 1'b0;
    b_valid_i     = 1'b0;
    b_ready_i     = 1'b0;
    b_id_i        = '0;
    reset_clear_i = 1'b0;
    set_budgets(24, 24, 24, 24);
    for (int p = 0; p < 4; p++) begin
      dur[p] = 0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    step(2);
    check("cause_o after reset", int'(cause_o), int'(CAUSE_NONE));
    check("full_o after reset", int'(full_o), 0);
    repeat (12) random_round();
    for (int p = 0; p < 4; p++) begin
      stall_round(p);
      random_round();
    end
    late_id_round();
    full_round();
    repeat (12) random_round();
    $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- verification/write_guard_props.sv
// Concurrent assertions on the write guard outputs
// Bound into every write_guard instance; failures show up as $error

`timescale 1ns/1ps

module write_guard_props (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   irq_o,
  input logic                   reset_req_o,
  input logic                   reset_clear_i,
  input wguard_pkg::tmo_cause_e cause_o
);

  import wguard_pkg::*;

  // Reset request and interrupt move together
  a_req_follows_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reset_req_o == irq_o)
    else $error("reset_req_o differs from irq_o");

  a_cause_set: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o |-> (cause_o != CAUSE_NONE))
    else $error("cause_o is empty while irq_o is high");

  // Interrupt is sticky until cleared
  a_irq_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(irq_o) |-> $past(reset_clear_i))
    else $error("irq_o dropped without reset_clear_i");

endmodule

bind write_guard write_guard_props u_props (
  .clk_i         ( clk_i         ),
  .rst_n_i       ( rst_n_i       ),
  .irq_o         ( irq_o         ),
  .reset_req_o   ( reset_req_o   ),
  .reset_clear_i ( reset_clear_i ),
  .cause_o       ( cause_o       )
);

//--- src/write_guard.sv
// Write-channel watchdog for an AXI-style bus
// Observes the AW, W and B handshakes between manager and subordinate,
// checks each transaction phase against its budget in prescaled ticks
// and raises a sticky interrupt and reset request on an overrun

`timescale 1ns/1ps
`include "wguard_cfg.svh"

module write_guard (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   aw_valid_i,
  input  logic                   aw_ready_i,
  input  logic [`WG_ID_W-1:0]    aw_id_i,
  input  logic                   w_valid_i,
  input  logic                   w_ready_i,
  input  logic                   w_last_i,
  input  logic                   b_valid_i,
  input  logic                   b_ready_i,
  input  logic [`WG_ID_W-1:0]    b_id_i,
  input  logic [`WG_CNT_W-1:0]   budget_aw_i,
  input  logic [`WG_CNT_W-1:0]   budget_w_i,
  input  logic [`WG_CNT_W-1:0]   budget_b_i,
  input  logic [`WG_CNT_W-1:0]   budget_brdy_i,
  input  logic                   reset_clear_i,
  output logic                   irq_o,
  output logic                   reset_req_o,
  output wguard_pkg::tmo_cause_e cause_o,
  output logic                   full_o
);

  import wguard_pkg::*;

  logic                aw_start, aw_hs, wlast_hs, bvld, b_hs, tick;
  logic [`WG_ID_W-1:0] aw_id, b_id;
  logic                aw_pending;
  logic                tmo;
  tmo_cause_e          tmo_cause;

  hs_sampler u_sampler (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .aw_valid_i   ( aw_valid_i ),
    .aw_ready_i   ( aw_ready_i ),
    .aw_id_i      ( aw_id_i    ),
    .w_valid_i    ( w_valid_i  ),
    .w_ready_i    ( w_ready_i  ),
    .w_last_i     ( w_last_i   ),
    .b_valid_i    ( b_valid_i  ),
    .b_ready_i    ( b_ready_i  ),
    .b_id_i       ( b_id_i     ),
    .aw_pending_i ( aw_pending ),
    .aw_start_o   ( aw_start   ),
    .aw_hs_o      ( aw_hs      ),
    .aw_id_o      ( aw_id      ),
    .wlast_hs_o   ( wlast_hs   ),
    .bvld_o       ( bvld       ),
    .b_hs_o       ( b_hs       ),
    .b_id_o       ( b_id       ),
    .tick_o       ( tick       )
  );

  // The pending reset request also drops every tracked entry
  txn_tracker u_tracker (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .flush_i       ( reset_req_o   ),
    .aw_start_i    ( aw_start      ),
    .aw_hs_i       ( aw_hs         ),
    .aw_id_i       ( aw_id         ),
    .wlast_hs_i    ( wlast_hs      ),
    .bvld_i        ( bvld          ),
    .b_hs_i        ( b_hs          ),
    .b_id_i        ( b_id          ),
    .tick_i        ( tick          ),
    .budget_aw_i   ( budget_aw_i   ),
    .budget_w_i    ( budget_w_i    ),
    .budget_b_i    ( budget_b_i    ),
    .budget_brdy_i ( budget_brdy_i ),
    .aw_pending_o  ( aw_pending    ),
    .full_o        ( full_o        ),
    .tmo_o         ( tmo           ),
    .tmo_cause_o   ( tmo_cause     )
  );

  timeout_handler u_handler (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .tmo_i         ( tmo           ),
    .tmo_cause_i   ( tmo_cause     ),
    .reset_clear_i ( reset_clear_i ),
    .irq_o         ( irq_o         ),
    .reset_req_o   ( reset_req_o   ),
    .cause_o       ( cause_o       )
  );

endmodule

//--- src/timeout_handler.sv
// Output side of the write guard
// Turns timeout pulses from the tracker into a sticky interrupt and
// reset request, and keeps the cause of the first timeout until cleared

`timescale 1ns/1ps

module timeout_handler (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   tmo_i,
  input  wguard_pkg::tmo_cause_e tmo_cause_i,
  input  logic                   reset_clear_i,
  output logic                   irq_o,
  output logic                   reset_req_o,
  output wguard_pkg::tmo_cause_e cause_o
);

  import wguard_pkg::*;

  // Sticky flags, cleared only by reset_clear_i
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || reset_clear_i) begin
      irq_o       <= 1'b0;
      reset_req_o <= 1'b0;
    end else if (tmo_i) begin
      irq_o       <= 1'b1;
      reset_req_o <= 1'b1;
    end
  end

  // Later timeouts leave the first cause in place
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || reset_clear_i) begin
      cause_o <= CAUSE_NONE;
    end else if (tmo_i && !irq_o) begin
      cause_o <= tmo_cause_i;
    end
  end

endmodule

//--- src/txn_tracker.sv
// Transaction table of the write guard
// Follows each write from AW request to B response through four phases,
// counts prescaled ticks per entry and flags the first budget overrun.
// B responses are matched by ID to the oldest entry waiting for them

`timescale 1ns/1ps
`include "wguard_cfg.svh"

module txn_tracker (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic                   aw_start_i,
  input  logic                   aw_hs_i,
  input  logic [`WG_ID_W-1:0]    aw_id_i,
  input  logic                   wlast_hs_i,
  input  logic                   bvld_i,
  input  logic                   b_hs_i,
  input  logic [`WG_ID_W-1:0]    b_id_i,
  input  logic                   tick_i,
  input  logic [`WG_CNT_W-1:0]   budget_aw_i,
  input  logic [`WG_CNT_W-1:0]   budget_w_i,
  input  logic [`WG_CNT_W-1:0]   budget_b_i,
  input  logic [`WG_CNT_W-1:0]   budget_brdy_i,
  output logic                   aw_pending_o,
  output logic                   full_o,
  output logic                   tmo_o,
  output wguard_pkg::tmo_cause_e tmo_cause_o
);

  import wguard_pkg::*;

  localparam int IDX_W = (`WG_TXNS > 1) ? $clog2(`WG_TXNS) : 1;

  txn_phase_e           phase_q [`WG_TXNS];
  txn_phase_e           phase_d [`WG_TXNS];
  logic [`WG_ID_W-1:0]  id_q    [`WG_TXNS];
  // Number of older entries, so the oldest has the smallest value
  logic [IDX_W-1:0]     age_q   [`WG_TXNS];
  logic [`WG_CNT_W-1:0] cnt_q   [`WG_TXNS];
  logic [`WG_TXNS-1:0]  frz_q;

  logic [`WG_TXNS-1:0]  free_vec, pend_vec, aw_vec, w_vec, b_vec, brdy_vec;
  logic [`WG_TXNS-1:0]  over_vec, move_vec;
  logic [IDX_W-1:0]     alloc_idx, aw_idx, w_idx, b_idx, r_idx, rel_idx, new_age;
  logic [IDX_W:0]       occ_cnt;
  logic                 alloc_ok, aw_mv, w_mv, w_late, b_mv, r_mv, rel_ok;
  logic [`WG_CNT_W-1:0] lim_sel;
  tmo_cause_e           cause_sel, cause_d;

  // Oldest candidate in a set of entries
  function automatic logic [IDX_W-1:0] oldest(input logic [`WG_TXNS-1:0] vec,
                                              input logic [IDX_W-1:0] ages [`WG_TXNS]);
    logic [IDX_W-1:0] sel;
    logic             hit;
    sel = '0;
    hit = 1'b0;
    for (int i = 0; i < `WG_TXNS; i++) begin
      if (vec[i] && (!hit || (ages[i] < ages[sel]))) begin
        sel = IDX_W'(i);
        hit = 1'b1;
      end
    end
    return sel;
  endfunction

  // Per-entry status; frozen entries take no more events
  always_comb begin
    occ_cnt   = '0;
    alloc_idx = '0;
    for (int i = `WG_TXNS - 1; i >= 0; i--) begin
      free_vec[i] = (phase_q[i] == PH_FREE);
      pend_vec[i] = (phase_q[i] == PH_AW);
      aw_vec[i]   = pend_vec[i] && !frz_q[i];
      w_vec[i]    = (phase_q[i] == PH_W) && !frz_q[i];
      b_vec[i]    = (phase_q[i] == PH_B) && !frz_q[i] && (id_q[i] == b_id_i);
      brdy_vec[i] = (phase_q[i] == PH_BRDY) && !frz_q[i] && (id_q[i] == b_id_i);
      if (free_vec[i]) begin
        alloc_idx = IDX_W'(i);
      end else begin
        occ_cnt = occ_cnt + 1'b1;
      end
    end
  end

  assign full_o       = ~(|free_vec);
  assign aw_pending_o = |pend_vec;

  assign aw_idx = oldest(aw_vec, age_q);
  assign w_idx  = oldest(w_vec, age_q);
  assign b_idx  = oldest(b_vec, age_q);
  assign r_idx  = oldest(brdy_vec, age_q);

  // A start together with a handshake is a request accepted at once
  assign alloc_ok = aw_start_i && !full_o;
  assign aw_mv    = aw_hs_i && !aw_start_i && (|aw_vec);
  assign w_mv     = wlast_hs_i && (|w_vec);
  // W last arriving with the AW handshake belongs to the newcomer
  assign w_late   = wlast_hs_i && !(|w_vec);
  assign b_mv     = bvld_i && (|b_vec);
  assign r_mv     = b_hs_i && !bvld_i && (|brdy_vec);
  assign rel_ok   = (b_mv && b_hs_i) || r_mv;
  assign rel_idx  = r_mv ? r_idx : b_idx;
  assign new_age  = IDX_W'(occ_cnt - rel_ok);

  always_comb begin
    for (int i = 0; i < `WG_TXNS; i++) begin
      phase_d[i] = phase_q[i];
      if (alloc_ok && (alloc_idx == IDX_W'(i))) begin
        if (!aw_hs_i) begin
          phase_d[i] = PH_AW;
        end else begin
          phase_d[i] = w_late ? PH_B : PH_W;
        end
      end
      if (aw_mv && (aw_idx == IDX_W'(i))) begin
        phase_d[i] = w_late ? PH_B : PH_W;
      end
      if (w_mv && (w_idx == IDX_W'(i))) begin
        phase_d[i] = PH_B;
      end
      if (b_mv && (b_idx == IDX_W'(i))) begin
        phase_d[i] = b_hs_i ? PH_FREE : PH_BRDY;
      end
      if (r_mv && (r_idx == IDX_W'(i))) begin
        phase_d[i] = PH_FREE;
      end
      move_vec[i] = (phase_d[i] != phase_q[i]);
    end
  end

  // Budget check, lowest overrunning entry sets the cause
  always_comb begin
    cause_d   = CAUSE_NONE;
    lim_sel   = '1;
    cause_sel = CAUSE_NONE;
    for (int i = `WG_TXNS - 1; i >= 0; i--) begin
      case (phase_q[i])
        PH_AW: begin
          lim_sel   = budget_aw_i;
          cause_sel = CAUSE_AW;
        end
        PH_W: begin
          lim_sel   = budget_w_i;
          cause_sel = CAUSE_W;
        end
        PH_B: begin
          lim_sel   = budget_b_i;
          cause_sel = CAUSE_B;
        end
        PH_BRDY: begin
          lim_sel   = budget_brdy_i;
          cause_sel = CAUSE_BRDY;
        end
        default: begin
          lim_sel   = '1;
          cause_sel = CAUSE_NONE;
        end
      endcase
      over_vec[i] = !frz_q[i] && !free_vec[i] && (cnt_q[i] > lim_sel);
      if (over_vec[i]) begin
        cause_d = cause_sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      for (int i = 0; i < `WG_TXNS; i++) begin
        phase_q[i] <= PH_FREE;
      end
      frz_q       <= '0;
      tmo_o       <= 1'b0;
      tmo_cause_o <= CAUSE_NONE;
    end else begin
      for (int i = 0; i < `WG_TXNS; i++) begin
        phase_q[i] <= phase_d[i];
      end
      frz_q       <= frz_q | over_vec;
      tmo_o       <= |over_vec;
      tmo_cause_o <= cause_d;
    end
  end

  // Counters restart on every phase change
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `WG_TXNS; i++) begin
      if (move_vec[i]) begin
        cnt_q[i] <= '0;
      end else if (tick_i && !free_vec[i] && !frz_q[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
      if (alloc_ok && (alloc_idx == IDX_W'(i))) begin
        id_q[i]  <= aw_id_i;
        age_q[i] <= new_age;
      end else if (rel_ok && !free_vec[i] && (age_q[i] > age_q[rel_idx])) begin
        // Younger entries move up when one leaves
        age_q[i] <= age_q[i] - 1'b1;
      end
    end
  end

endmodule

//--- src/hs_sampler.sv
// Bus side of the write guard
// Turns the raw AW, W and B levels into one-cycle registered event
// strobes and generates the prescaled tick for the phase counters

`timescale 1ns/1ps
`include "wguard_cfg.svh"

module hs_sampler (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                aw_valid_i,
  input  logic                aw_ready_i,
  input  logic [`WG_ID_W-1:0] aw_id_i,
  input  logic                w_valid_i,
  input  logic                w_ready_i,
  input  logic                w_last_i,
  input  logic                b_valid_i,
  input  logic                b_ready_i,
  input  logic [`WG_ID_W-1:0] b_id_i,
  input  logic                aw_pending_i,
  output logic                aw_start_o,
  output logic                aw_hs_o,
  output logic [`WG_ID_W-1:0] aw_id_o,
  output logic                wlast_hs_o,
  output logic                bvld_o,
  output logic                b_hs_o,
  output logic [`WG_ID_W-1:0] b_id_o,
  output logic                tick_o
);

  localparam int PS_W = (`WG_PRESCALE > 1) ? $clog2(`WG_PRESCALE) : 1;

  logic [PS_W-1:0] ps_cnt_q;
  logic            b_open_q;
  logic            aw_start_d;

  // A request is new when nothing is open and none was just flagged,
  // or when the channel completed a handshake in the previous cycle
  assign aw_start_d = aw_valid_i & ((~aw_pending_i & ~aw_start_o) | aw_hs_o);

  // Prescaler
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ps_cnt_q <= '0;
      tick_o   <= 1'b0;
    end else if (ps_cnt_q == PS_W'(`WG_PRESCALE - 1)) begin
      ps_cnt_q <= '0;
      tick_o   <= 1'b1;
    end else begin
      ps_cnt_q <= ps_cnt_q + 1'b1;
      tick_o   <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_start_o <= 1'b0;
      aw_hs_o    <= 1'b0;
      wlast_hs_o <= 1'b0;
      bvld_o     <= 1'b0;
      b_hs_o     <= 1'b0;
      b_open_q   <= 1'b0;
    end else begin
      aw_start_o <= aw_start_d;
      aw_hs_o    <= aw_valid_i & aw_ready_i;
      wlast_hs_o <= w_valid_i & w_ready_i & w_last_i;
      // Only the first cycle of a B beat counts as B valid
      bvld_o     <= b_valid_i & ~b_open_q;
      b_hs_o     <= b_valid_i & b_ready_i;
      b_open_q   <= b_valid_i & ~b_ready_i;
    end
  end

  // IDs travel with their strobes
  always_ff @(posedge clk_i) begin
    aw_id_o <= aw_id_i;
    b_id_o  <= b_id_i;
  end

endmodule

//--- src/wguard_pkg.sv
// Shared enums of the write guard
// Imported by the tracker, the timeout handler and the top level;
// the testbench uses the cause values to check cause_o

package wguard_pkg;

  // Phase a table entry is in
  typedef enum logic [2:0] {
    PH_FREE = 3'd0,
    PH_AW   = 3'd1,  // AW valid seen, waiting for AW ready
    PH_W    = 3'd2,  // AW accepted, waiting for the last W beat
    PH_B    = 3'd3,  // W last seen, waiting for B valid
    PH_BRDY = 3'd4   // B valid seen, waiting for B ready
  } txn_phase_e;

  // Budget that was overrun first
  typedef enum logic [2:0] {
    CAUSE_NONE = 3'd0,
    CAUSE_AW   = 3'd1,
    CAUSE_W    = 3'd2,
    CAUSE_B    = 3'd3,
    CAUSE_BRDY = 3'd4
  } tmo_cause_e;

endpackage

//--- src/wguard_cfg.svh
// Build-time sizes of the write guard
// Included by every RTL file that sizes the transaction table,
// the ID fields, the tick counters or the prescaler

`ifndef WGUARD_CFG_SVH
`define WGUARD_CFG_SVH

// Transactions tracked at the same time
`define WG_TXNS 4

// Width of the AW and B IDs
`define WG_ID_W 4

// Width of the tick counters and of the budget inputs
`define WG_CNT_W 8

// Clock cycles per counter tick
`define WG_PRESCALE 4

`endif
